// File: tb.f
+incdir+design
+incdir+bench
design/aes_pkg.sv
design/aes_round_ctrl.sv
design/aes_key_schedule.sv
design/aes_inv_round.sv
design/aes_result.sv
design/aes_inv_cipher.sv
bench/tb_aes_inv_cipher.sv

// File: bench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// What the stimulus loop does with a row
typedef enum logic [1:0] {
  ACT_NORMAL,      // Idle gap, then one block
  ACT_BUSY_START,  // Second start with alt_ct while the block runs
  ACT_BACK2BACK,   // Started in the done cycle of the row before
  ACT_RESET_MID    // Reset part way through, no result expected
} vec_action_e;

typedef struct packed {
  vec_action_e             action;
  logic [`AES_BLOCK_W-1:0] key;
  logic [`AES_BLOCK_W-1:0] ct;
  logic [`AES_BLOCK_W-1:0] pt;      // Expected plaintext
  logic [`AES_BLOCK_W-1:0] alt_ct;  // Interfering ciphertext
} vec_row_t;

localparam int NUM_ROWS = 7;

// FIPS-197 appendix C.1
localparam logic [`AES_BLOCK_W-1:0] KEY_C1 = 128'h000102030405060708090a0b0c0d0e0f;
localparam logic [`AES_BLOCK_W-1:0] CT_C1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
localparam logic [`AES_BLOCK_W-1:0] PT_C1  = 128'h00112233445566778899aabbccddeeff;

// FIPS-197 appendix B
localparam logic [`AES_BLOCK_W-1:0] KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
localparam logic [`AES_BLOCK_W-1:0] CT_B  = 128'h3925841d02dc09fbdc118597196a0b32;
localparam logic [`AES_BLOCK_W-1:0] PT_B  = 128'h3243f6a8885a308d313198a2e0370734;

// All-zero key and all-zero block
localparam logic [`AES_BLOCK_W-1:0] CT_ZERO = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

// Columns: action, key, ciphertext, expected plaintext, interfering ciphertext
function automatic vec_row_t vector_row(input int idx);
  case (idx)
    0:       return {ACT_NORMAL,     KEY_C1, CT_C1,   PT_C1, 128'h0};
    1:       return {ACT_BACK2BACK,  KEY_B,  CT_B,    PT_B,  128'h0};
    2:       return {ACT_BUSY_START, KEY_C1, CT_C1,   PT_C1, CT_B};
    3:       return {ACT_RESET_MID,  KEY_B,  CT_B,    PT_B,  128'h0};
    4:       return {ACT_NORMAL,     KEY_B,  CT_B,    PT_B,  128'h0};
    5:       return {ACT_BACK2BACK,  128'h0, CT_ZERO, 128'h0, 128'h0};
    default: return {ACT_NORMAL,     KEY_C1, CT_C1,   PT_C1, 128'h0};
  endcase
endfunction

`endif

// File: bench/tb_aes_inv_cipher.sv
`timescale 1ns/100ps
`default_nettype none
`include "aes_config.svh"

module tb_aes_inv_cipher;

  localparam int CLK_PERIOD = 4;
  localparam int LATENCY    = 21;  // Sampling edge of start to done
  localparam int WAIT_LIMIT = 40;
  localparam int RESET_AT   = 8;   // Cycles into a block before the mid-run reset

  `include "tb_vectors.svh"

  logic                    clk;
  logic                    rst_n;
  logic                    start;
  logic [`AES_BLOCK_W-1:0] ciphertext;
  logic [`AES_BLOCK_W-1:0] key;
  logic [`AES_BLOCK_W-1:0] plaintext;
  logic                    done;
  logic                    busy;

  logic [`AES_BLOCK_W-1:0] held_pt;  // What plaintext must show between completions
  int                      errors;
  int                      checks;

  aes_inv_cipher i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .ciphertext (ciphertext),
    .key        (key),
    .plaintext  (plaintext),
    .done       (done),
    .busy       (busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Roughly 30 cycles per row plus reset
  initial begin
    #((NUM_ROWS * 30 + 20) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", NUM_ROWS * 30 + 20);
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic check_value(
    input string                   name,
    input logic [`AES_BLOCK_W-1:0] got,
    input logic [`AES_BLOCK_W-1:0] exp
  );
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // One clock, then 1 ns past the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      next_cycle();
      check_value("done", done, 1'b0);
      check_value("busy", busy, 1'b0);
      check_value("plaintext", plaintext, held_pt);
    end
  endtask

  // Returns just after the sampling edge
  task automatic start_block(input vec_row_t row);
    start      = 1'b1;
    key        = row.key;
    ciphertext = row.ct;
    next_cycle();
    start      = 1'b0;
    key        = ~row.key;  // Must not be sampled again
    ciphertext = ~row.ct;
    check_value("busy", busy, 1'b1);
    check_value("done", done, 1'b0);
    check_value("plaintext", plaintext, held_pt);
  endtask

  task automatic finish_block(input vec_row_t row);
    int lat;
    lat = 0;
    while (!done && lat < WAIT_LIMIT) begin
      if (row.action == ACT_BUSY_START && lat == 5) begin
        start      = 1'b1;
        ciphertext = row.alt_ct;
      end
      next_cycle();
      start = 1'b0;
      lat++;
      if (!done) begin
        check_value("busy", busy, 1'b1);
      end
    end
    if (!done) begin
      errors++;
      $display("Error at %0t: done did not come within %0d cycles of start",
               $time, WAIT_LIMIT);
    end else begin
      check_value("latency", lat, LATENCY);
      check_value("busy", busy, 1'b0);
      check_value("plaintext", plaintext, row.pt);
      held_pt = row.pt;
    end
  endtask

  task automatic reset_mid_run();
    repeat (RESET_AT) next_cycle();
    rst_n = 1'b0;
    repeat (2) next_cycle();
    check_value("busy", busy, 1'b0);
    check_value("done", done, 1'b0);
    check_value("plaintext", plaintext, '0);
    rst_n   = 1'b1;
    held_pt = '0;
  endtask

  initial begin
    vec_row_t row;
    errors     = 0;
    checks     = 0;
    held_pt    = '0;
    rst_n      = 1'b0;
    start      = 1'b0;
    key        = '0;
    ciphertext = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      row = vector_row(i);
      if (row.action != ACT_BACK2BACK) begin
        idle_cycles(2);
      end
      start_block(row);
      if (row.action == ACT_RESET_MID) begin
        reset_mid_run();
      end else begin
        finish_block(row);
        if (row.action == ACT_BUSY_START) begin
          idle_cycles(LATENCY + 4);  // The ignored start gives no second done
        end
      end
    end
    idle_cycles(2);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/aes_inv_cipher.sv
`timescale 1ns/100ps
`default_nettype none
`include "aes_config.svh"

module aes_inv_cipher (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  logic [`AES_BLOCK_W-1:0] ciphertext,
  input  logic [`AES_BLOCK_W-1:0] key,
  output logic [`AES_BLOCK_W-1:0] plaintext,
  output logic                    done,
  output logic                    busy
);

  aes_pkg::aes_ctrl_t  ctrl;
  aes_pkg::aes_state_u round_key;
  aes_pkg::aes_state_u next_state;

  aes_round_ctrl i_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .ctrl  (ctrl),
    .busy  (busy)
  );

  aes_key_schedule i_key (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .key       (key),
    .round_key (round_key)
  );

  // Round register is internal, the result stage takes the combinational value
  aes_inv_round i_round (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .ciphertext (ciphertext),
    .round_key  (round_key),
    .state      (),
    .next_state (next_state)
  );

  aes_result i_result (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .next_state (next_state),
    .plaintext  (plaintext),
    .done       (done)
  );

endmodule

`default_nettype wire

// File: design/aes_result.sv
`timescale 1ns/100ps
`default_nettype none
`include "aes_config.svh"

module aes_result (
  input  logic                    clk,
  input  logic                    rst_n,
  input  aes_pkg::aes_ctrl_t      ctrl,
  input  aes_pkg::aes_state_u     next_state,
  output logic [`AES_BLOCK_W-1:0] plaintext,
  output logic                    done
);

  // Plaintext holds until the next block finishes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      plaintext <= '0;
      done      <= 1'b0;
    end else begin
      done <= ctrl.last;  // One pulse per block
      if (ctrl.last) begin
        plaintext <= next_state;
      end
    end
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done);

endmodule

`default_nettype wire

// File: design/aes_inv_round.sv
`timescale 1ns/100ps
`default_nettype none
`include "aes_config.svh"

module aes_inv_round (
  input  logic                    clk,
  input  logic                    rst_n,
  input  aes_pkg::aes_ctrl_t      ctrl,
  input  logic [`AES_BLOCK_W-1:0] ciphertext,
  input  aes_pkg::aes_state_u     round_key,
  output aes_pkg::aes_state_u     state,
  output aes_pkg::aes_state_u     next_state  // Final round result, combinational
);

  aes_pkg::aes_state_u shifted;
  aes_pkg::aes_state_u subbed;
  aes_pkg::aes_state_u keyed;
  aes_pkg::aes_state_u mixed;

  // Inverse mix of one column, rows are rotations of 0e 0b 0d 09
  function automatic logic [`AES_WORD_W-1:0] inv_mix_col(
    input logic [`AES_WORD_W-1:0] w
  );
    logic [0:3][`AES_BYTE_W-1:0] a;
    logic [0:3][`AES_BYTE_W-1:0] m;
    a = w;
    for (int r = 0; r < 4; r++) begin
      m[r] = aes_pkg::gf_mul(a[r], 8'h0e) ^
             aes_pkg::gf_mul(a[(r + 1) % 4], 8'h0b) ^
             aes_pkg::gf_mul(a[(r + 2) % 4], 8'h0d) ^
             aes_pkg::gf_mul(a[(r + 3) % 4], 8'h09);
    end
    return m;
  endfunction

  // Row r moves right by r columns
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.bytes[4*c + r] = state.bytes[4*((c - r + 4) % 4) + r];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 16; i++) begin
      subbed.bytes[i] = aes_pkg::sbox_inv(shifted.bytes[i]);
    end
  end

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      keyed.col[c] = subbed.col[c] ^ round_key.col[c];
    end
  end

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mixed.col[c] = inv_mix_col(keyed.col[c]);
    end
  end

  assign next_state = keyed;  // Last round skips mix columns

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= '0;
    end else if (ctrl.load) begin
      state <= ciphertext;
    end else if (ctrl.first) begin
      state <= state ^ round_key;  // Whitening with round key 10
    end else if (ctrl.round_en) begin
      state <= mixed;
    end else if (ctrl.last) begin
      state <= keyed;
    end
  end

endmodule

`default_nettype wire

// File: design/aes_key_schedule.sv
`timescale 1ns/100ps
`default_nettype none
`include "aes_config.svh"

module aes_key_schedule (
  input  logic                    clk,
  input  logic                    rst_n,
  input  aes_pkg::aes_ctrl_t      ctrl,
  input  logic [`AES_BLOCK_W-1:0] key,
  output aes_pkg::aes_state_u     round_key
);

  localparam logic [`AES_CNT_W-1:0] LAST_IDX = `AES_CNT_W'(`AES_NUM_ROUNDS);

  logic [`AES_CNT_W-1:0] idx;      // Round number of round_key
  aes_pkg::aes_state_u   fwd_key;
  aes_pkg::aes_state_u   bwd_key;

  // RotWord, SubWord and round constant on one word
  function automatic logic [`AES_WORD_W-1:0] key_g(
    input logic [`AES_WORD_W-1:0] w,
    input aes_pkg::aes_rcon_t     rc
  );
    logic [`AES_WORD_W-1:0] rot;
    rot = {w[23:0], w[31:24]};
    return {aes_pkg::sbox_fwd(rot[31:24]) ^ rc,
            aes_pkg::sbox_fwd(rot[23:16]),
            aes_pkg::sbox_fwd(rot[15:8]),
            aes_pkg::sbox_fwd(rot[7:0])};
  endfunction

  always_comb begin
    fwd_key.col[0] = round_key.col[0] ^
                     key_g(round_key.col[3], aes_pkg::rcon_of(idx + 1'b1));
    fwd_key.col[1] = round_key.col[1] ^ fwd_key.col[0];
    fwd_key.col[2] = round_key.col[2] ^ fwd_key.col[1];
    fwd_key.col[3] = round_key.col[3] ^ fwd_key.col[2];
  end

  // Undo the chain from the right, then the first word needs the old last word
  always_comb begin
    bwd_key.col[3] = round_key.col[3] ^ round_key.col[2];
    bwd_key.col[2] = round_key.col[2] ^ round_key.col[1];
    bwd_key.col[1] = round_key.col[1] ^ round_key.col[0];
    bwd_key.col[0] = round_key.col[0] ^
                     key_g(bwd_key.col[3], aes_pkg::rcon_of(idx));
  end

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      round_key <= key;
    end else if (ctrl.fwd_step) begin
      round_key <= fwd_key;
    end else if (ctrl.bwd_step) begin
      round_key <= bwd_key;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx <= '0;
    end else if (ctrl.load) begin
      idx <= '0;
    end else if (ctrl.fwd_step) begin
      idx <= idx + 1'b1;
    end else if (ctrl.bwd_step) begin
      idx <= idx - 1'b1;
    end
  end

  a_step_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl.fwd_step && ctrl.bwd_step));

  // Decryption opens on round key 10 and closes on the cipher key
  a_key_align: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl.first |-> idx == LAST_IDX) and (ctrl.last |-> idx == '0));

endmodule

`default_nettype wire

// File: design/aes_round_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "aes_config.svh"

module aes_round_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  output aes_pkg::aes_ctrl_t ctrl,
  output logic               busy
);

  localparam logic [1:0] PH_IDLE    = 2'd0;
  localparam logic [1:0] PH_EXPAND  = 2'd1;  // Key schedule runs forward
  localparam logic [1:0] PH_DECRYPT = 2'd2;  // Rounds with the key walking back

  localparam logic [`AES_CNT_W-1:0] LAST_CNT = `AES_CNT_W'(`AES_NUM_ROUNDS);
  localparam logic [`AES_CNT_W-1:0] EXP_END  = `AES_CNT_W'(`AES_NUM_ROUNDS - 1);

  logic [1:0]            phase;
  logic [`AES_CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= PH_IDLE;
      cnt   <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (start) begin
            phase <= PH_EXPAND;
            cnt   <= '0;
          end
        end
        PH_EXPAND: begin
          if (cnt == EXP_END) begin  // Tenth forward step
            phase <= PH_DECRYPT;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        PH_DECRYPT: begin
          if (cnt == LAST_CNT) begin
            phase <= PH_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  // cnt 0 is the key addition, 1..9 full rounds, 10 the final round
  always_comb begin
    ctrl          = '0;
    ctrl.load     = (phase == PH_IDLE) && start;
    ctrl.fwd_step = (phase == PH_EXPAND);
    ctrl.bwd_step = (phase == PH_DECRYPT) && (cnt != LAST_CNT);
    ctrl.first    = (phase == PH_DECRYPT) && (cnt == '0);
    ctrl.round_en = (phase == PH_DECRYPT) && (cnt != '0) && (cnt != LAST_CNT);
    ctrl.last     = (phase == PH_DECRYPT) && (cnt == LAST_CNT);
  end

  assign busy = (phase != PH_IDLE);

  // Rounds run unbroken from the key addition to the final round
  a_round_order: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl.first || ctrl.round_en) |=> (ctrl.round_en || ctrl.last));

  a_last_idle: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.last |=> !busy);

endmodule

`default_nettype wire

// File: design/aes_pkg.sv
`default_nettype none
`include "aes_config.svh"

package aes_pkg;

  // State or round key, seen as columns or as bytes
  typedef union packed {
    logic [0:3][`AES_WORD_W-1:0]  col;    // col[0] is the leftmost word
    logic [0:15][`AES_BYTE_W-1:0] bytes;  // bytes[4*c+r] is row r of column c
  } aes_state_u;

  // Sequencer strobes, each one acts at the edge where it is high
  typedef struct packed {
    logic load;      // Capture ciphertext and key
    logic fwd_step;  // Key schedule one round forward
    logic bwd_step;  // Key schedule one round back
    logic first;     // Initial key addition
    logic round_en;  // Full inverse round
    logic last;      // Final round, no mix columns
  } aes_ctrl_t;

  typedef logic [`AES_BYTE_W-1:0] aes_rcon_t;

  // Multiply by x modulo the AES polynomial
  function automatic logic [`AES_BYTE_W-1:0] xtime(input logic [`AES_BYTE_W-1:0] a);
    return {a[6:0], 1'b0} ^ (8'h1b & {8{a[7]}});
  endfunction

  function automatic logic [`AES_BYTE_W-1:0] gf_mul(
    input logic [`AES_BYTE_W-1:0] a,
    input logic [`AES_BYTE_W-1:0] b
  );
    logic [`AES_BYTE_W-1:0] acc;
    logic [`AES_BYTE_W-1:0] sh;
    acc = '0;
    sh  = a;
    for (int i = 0; i < `AES_BYTE_W; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = xtime(sh);
    end
    return acc;
  endfunction

  // Inverse as a^254, which also sends zero to zero
  function automatic logic [`AES_BYTE_W-1:0] gf_inv(input logic [`AES_BYTE_W-1:0] a);
    logic [`AES_BYTE_W-1:0] sq;
    logic [`AES_BYTE_W-1:0] res;
    sq  = a;
    res = 8'h01;
    for (int i = 0; i < 7; i++) begin
      sq  = gf_mul(sq, sq);   // a^2, a^4 ... a^128
      res = gf_mul(res, sq);
    end
    return res;
  endfunction

  function automatic logic [`AES_BYTE_W-1:0] rotl8(
    input logic [`AES_BYTE_W-1:0] x,
    input int                     n
  );
    return (x << n) | (x >> (`AES_BYTE_W - n));
  endfunction

  // Inversion followed by the affine map
  function automatic logic [`AES_BYTE_W-1:0] sbox_fwd(input logic [`AES_BYTE_W-1:0] a);
    logic [`AES_BYTE_W-1:0] v;
    v = gf_inv(a);
    return v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
  endfunction

  // Inverse affine map first, then the same inversion
  function automatic logic [`AES_BYTE_W-1:0] sbox_inv(input logic [`AES_BYTE_W-1:0] a);
    return gf_inv(rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05);
  endfunction

  // Round constant x^(rnd-1), rnd counted from 1
  function automatic aes_rcon_t rcon_of(input logic [`AES_CNT_W-1:0] rnd);
    aes_rcon_t rc;
    rc = 8'h01;
    for (int i = 1; i < `AES_NUM_ROUNDS; i++) begin
      if (i < rnd) begin
        rc = xtime(rc);
      end
    end
    return rc;
  endfunction

endpackage

`default_nettype wire

// File: design/aes_config.svh
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// AES-128 block geometry
`define AES_BLOCK_W 128
`define AES_WORD_W 32      // One state column or key word
`define AES_BYTE_W 8

// Round structure
`define AES_NUM_ROUNDS 10
`define AES_CNT_W 4        // Enough for round index 0..10

`endif
